// File: hdl/img_macros.svh
`ifndef IMG_MACROS_SVH
`define IMG_MACROS_SVH

// image geometry
`define IMG_W       8
`define IMG_H       8
`define IMG_C       32
`define IMG_PIX     (`IMG_W * `IMG_H * `IMG_C)  // 2048 bytes per load

// banked storage, one bank per channel mod 4
`define BANK_COUNT  4
`define BANK_DEPTH  512

`define ORG_MAX     3'd6    // 2x2 window must fit inside 8x8

// opcodes
`define OP_LOAD     4'd0
`define OP_ORG_R    4'd1
`define OP_ORG_L    4'd2
`define OP_ORG_U    4'd3
`define OP_ORG_D    4'd4
`define OP_SCALE_D  4'd5
`define OP_SCALE_U  4'd6
`define OP_DISPLAY  4'd7

// channel depth codes
`define DEPTH_8     2'd0
`define DEPTH_16    2'd1
`define DEPTH_32    2'd2

`endif

// File: hdl/img_pkg.sv
package img_pkg;

    // --------------------------------------------------
    // data and index widths
    // --------------------------------------------------
    typedef logic [7:0]  pixel_t;       // one stored byte
    typedef logic [2:0]  coord_t;       // x or y
    typedef logic [4:0]  chan_t;        // channel 0..31
    typedef logic [1:0]  bank_sel_t;    // channel mod 4
    typedef logic [8:0]  bank_addr_t;   // (c/4)*64 + y*8 + x
    typedef logic [10:0] load_idx_t;    // raster index {c, y, x}
    typedef logic [1:0]  depth_sel_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [13:0] out_data_t;    // zero-extended pixel

    // --------------------------------------------------
    // command FSM
    // --------------------------------------------------
    typedef enum logic [2:0] {
        ST_READY,       // after reset, announce first ready
        ST_WAIT_OP,     // waiting for op pulse
        ST_LOAD,        // load engine busy
        ST_ADJUST,      // origin / depth update
        ST_DISPLAY      // display engine busy
    } ctrl_state_t;

endpackage

// File: hdl/bank_if.sv
`timescale 1ns/1ps

interface bank_if;
    import img_pkg::*;

    // write side, load engine
    logic       wr_en;
    bank_addr_t wr_addr;
    pixel_t     wr_data;

    // read side, display engine
    logic       rd_en;
    bank_addr_t rd_addr;
    pixel_t     rd_data;    // valid one cycle after rd_en

    modport writer (
        output wr_en, wr_addr, wr_data
    );

    modport reader (
        output rd_en, rd_addr,
        input  rd_data
    );

    modport bank (
        input  wr_en, wr_addr, wr_data, rd_en, rd_addr,
        output rd_data
    );

endinterface

// File: hdl/pixel_bank.sv
`timescale 1ns/1ps
`include "img_macros.svh"

module pixel_bank (
    input logic     i_clk,
    bank_if.bank    io
);
    import img_pkg::*;

    pixel_t mem [`BANK_DEPTH];  // 512 x 8 storage

    // write port
    always_ff @(posedge i_clk) begin
        if (io.wr_en) begin
            mem[io.wr_addr] <= io.wr_data;
        end
    end

    // registered read, data lands next cycle
    always_ff @(posedge i_clk) begin
        if (io.rd_en) begin
            io.rd_data <= mem[io.rd_addr];
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    // load and display engines are never both active
    a_no_rw_overlap: assert property (@(posedge i_clk) !(io.wr_en && io.rd_en))
        else $error("bank read and write in same cycle");

endmodule

// File: hdl/op_ctrl.sv
`timescale 1ns/1ps
`include "img_macros.svh"

module op_ctrl (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_op_valid,
    input  img_pkg::opcode_t    i_op_mode,
    input  logic                i_load_done,
    input  logic                i_disp_done,
    output logic                o_op_ready,
    output logic                o_load_start,
    output logic                o_disp_start,
    output img_pkg::coord_t     o_origin_x,
    output img_pkg::coord_t     o_origin_y,
    output img_pkg::depth_sel_t o_depth_sel
);
    import img_pkg::*;

    ctrl_state_t state;
    opcode_t     op_q;      // op held for the adjust cycle
    logic        op_take;

    // op accepted only while waiting
    assign op_take      = (state == ST_WAIT_OP) && i_op_valid;
    // engine starts go out in the op cycle itself
    assign o_load_start = op_take && (i_op_mode == `OP_LOAD);
    assign o_disp_start = op_take && (i_op_mode == `OP_DISPLAY);

    // --------------------------------------------------
    // command FSM with origin and depth registers
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= ST_READY;
            o_op_ready  <= 1'b0;
            o_origin_x  <= '0;
            o_origin_y  <= '0;
            o_depth_sel <= `DEPTH_32;  // full depth by default
        end else begin
            o_op_ready <= 1'b0;     // single-cycle pulse
            case (state)
                ST_READY: begin
                    o_op_ready <= 1'b1;
                    state      <= ST_WAIT_OP;
                end
                ST_WAIT_OP: begin
                    if (o_load_start) begin
                        state <= ST_LOAD;
                    end else if (o_disp_start) begin
                        state <= ST_DISPLAY;
                    end else if (op_take) begin
                        state <= ST_ADJUST;   // shifts, scales and unknown ops
                    end
                end
                ST_ADJUST: begin
                    case (op_q)
                        `OP_ORG_R:   if (o_origin_x < `ORG_MAX) o_origin_x <= o_origin_x + 3'd1;
                        `OP_ORG_L:   if (o_origin_x != 3'd0)    o_origin_x <= o_origin_x - 3'd1;
                        `OP_ORG_U:   if (o_origin_y != 3'd0)    o_origin_y <= o_origin_y - 3'd1;
                        `OP_ORG_D:   if (o_origin_y < `ORG_MAX) o_origin_y <= o_origin_y + 3'd1;
                        `OP_SCALE_D: if (o_depth_sel != `DEPTH_8) begin
                            o_depth_sel <= o_depth_sel - 2'd1;
                        end
                        `OP_SCALE_U: if (o_depth_sel != `DEPTH_32) begin
                            o_depth_sel <= o_depth_sel + 2'd1;
                        end
                        default: ;  // undefined opcode, no effect
                    endcase
                    o_op_ready <= 1'b1;
                    state      <= ST_WAIT_OP;
                end
                ST_LOAD: begin
                    if (i_load_done) begin
                        o_op_ready <= 1'b1;
                        state      <= ST_WAIT_OP;
                    end
                end
                ST_DISPLAY: begin
                    if (i_disp_done) begin
                        o_op_ready <= 1'b1;
                        state      <= ST_WAIT_OP;
                    end
                end
                default: state <= ST_WAIT_OP;
            endcase
        end
    end

    // opcode capture, no reset needed for payload
    always_ff @(posedge i_clk) begin
        if (op_take) begin
            op_q <= i_op_mode;
        end
    end

    // engine done only while that engine owns the core
    a_load_done_state: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_load_done |-> state == ST_LOAD)
        else $error("load done outside ST_LOAD");
    a_disp_done_state: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_disp_done |-> state == ST_DISPLAY)
        else $error("display done outside ST_DISPLAY");

endmodule

// File: hdl/load_writer.sv
`timescale 1ns/1ps
`include "img_macros.svh"

module load_writer (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_start,
    input  logic            i_in_valid,
    input  img_pkg::pixel_t i_in_data,
    output logic            o_in_ready,
    output logic            o_done,
    bank_if.writer          o_banks [`BANK_COUNT]
);
    import img_pkg::*;

    load_idx_t  idx;        // raster position of next byte
    logic       take;       // handshake fires
    bank_sel_t  sel;
    bank_addr_t addr;

    assign take = i_in_valid && o_in_ready;
    // idx = {c[4:0], y[2:0], x[2:0]}, bank is c mod 4
    assign sel  = idx[7:6];
    assign addr = {idx[10:8], idx[5:0]};   // (c/4)*64 + y*8 + x

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            idx        <= '0;
            o_in_ready <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                idx        <= '0;
                o_in_ready <= 1'b1;
            end else if (take) begin
                idx <= idx + 1'b1;
                if (idx == load_idx_t'(`IMG_PIX - 1)) begin
                    o_in_ready <= 1'b0;     // last byte taken
                    o_done     <= 1'b1;
                end
            end
        end
    end

    // write strobe only to the addressed bank
    for (genvar g = 0; g < `BANK_COUNT; g++) begin : g_wr
        assign o_banks[g].wr_en   = take && (sel == bank_sel_t'(g));
        assign o_banks[g].wr_addr = addr;
        assign o_banks[g].wr_data = i_in_data;
    end

endmodule

// File: hdl/display_reader.sv
`timescale 1ns/1ps
`include "img_macros.svh"

module display_reader (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  img_pkg::coord_t     i_origin_x,
    input  img_pkg::coord_t     i_origin_y,
    input  img_pkg::depth_sel_t i_depth_sel,
    output logic                o_done,
    output logic                o_out_valid,
    output img_pkg::out_data_t  o_out_data,
    bank_if.reader              o_banks [`BANK_COUNT]
);
    import img_pkg::*;

    logic       active;             // address stage busy
    logic [1:0] pos;                // 0:(x,y) 1:(x+1,y) 2:(x,y+1) 3:(x+1,y+1)
    chan_t      chan;
    logic [5:0] chan_cnt;           // 8, 16 or 32
    chan_t      last_chan;
    coord_t     px, py;
    bank_sel_t  bank;
    bank_addr_t addr;
    logic       pipe_valid;         // read in flight
    bank_sel_t  pipe_sel;           // which bank answers
    pixel_t     rd_bytes [`BANK_COUNT];

    always_comb begin
        case (i_depth_sel)
            `DEPTH_8:  chan_cnt = 6'd8;
            `DEPTH_16: chan_cnt = 6'd16;
            default:   chan_cnt = 6'(`IMG_C);
        endcase
    end
    assign last_chan = chan_t'(chan_cnt - 6'd1);

    // --------------------------------------------------
    // address stage
    // --------------------------------------------------
    assign px   = i_origin_x + coord_t'(pos[0]);
    assign py   = i_origin_y + coord_t'(pos[1]);
    assign bank = chan[1:0];
    assign addr = bank_addr_t'((chan >> 2) * (`IMG_W * `IMG_H) + py * `IMG_W + px);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active <= 1'b0;
            pos    <= '0;
            chan   <= '0;
        end else if (i_start) begin
            active <= 1'b1;
            pos    <= '0;
            chan   <= '0;
        end else if (active) begin
            pos <= pos + 2'd1;
            if (pos == 2'd3) begin
                if (chan == last_chan) active <= 1'b0;  // final window read issued
                else chan <= chan + 1'b1;
            end
        end
    end

    for (genvar g = 0; g < `BANK_COUNT; g++) begin : g_rd
        assign o_banks[g].rd_en   = active && (bank == bank_sel_t'(g));
        assign o_banks[g].rd_addr = addr;
        assign rd_bytes[g]        = o_banks[g].rd_data;
    end

    // --------------------------------------------------
    // read tracking and output register
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pipe_valid  <= 1'b0;
            o_out_valid <= 1'b0;
            o_done      <= 1'b0;
        end else begin
            pipe_valid  <= active;
            o_out_valid <= pipe_valid;
            o_done      <= o_out_valid && !pipe_valid;  // last word leaving
        end
    end

    always_ff @(posedge i_clk) begin
        pipe_sel <= bank;
        if (pipe_valid) o_out_data <= out_data_t'(rd_bytes[pipe_sel]);  // zero-extend
    end

endmodule

// File: hdl/img_core.sv
`timescale 1ns/1ps
`include "img_macros.svh"

module img_core (
    input  logic                i_clk,
    input  logic                i_rst_n,        // async, active low
    input  logic                i_op_valid,     // one-cycle op pulse
    input  img_pkg::opcode_t    i_op_mode,
    input  logic                i_in_valid,     // pixel input, LOAD only
    input  img_pkg::pixel_t     i_in_data,
    output logic                o_op_ready,     // pulse, next op welcome
    output logic                o_in_ready,
    output logic                o_out_valid,    // display stream, no back-pressure
    output img_pkg::out_data_t  o_out_data
);
    import img_pkg::*;

    logic       load_start, load_done;
    logic       disp_start, disp_done;
    coord_t     origin_x, origin_y;
    depth_sel_t depth_sel;

    bank_if banks [`BANK_COUNT] ();     // one link per bank

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    op_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_op_valid   (i_op_valid),
        .i_op_mode    (i_op_mode),
        .i_load_done  (load_done),
        .i_disp_done  (disp_done),
        .o_op_ready   (o_op_ready),
        .o_load_start (load_start),
        .o_disp_start (disp_start),
        .o_origin_x   (origin_x),
        .o_origin_y   (origin_y),
        .o_depth_sel  (depth_sel)
    );

    load_writer u_load (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (load_start),
        .i_in_valid (i_in_valid),
        .i_in_data  (i_in_data),
        .o_in_ready (o_in_ready),
        .o_done     (load_done),
        .o_banks    (banks)
    );

    // storage, bank = channel mod 4
    for (genvar g = 0; g < `BANK_COUNT; g++) begin : g_bank
        pixel_bank u_bank (
            .i_clk (i_clk),
            .io    (banks[g])
        );
    end

    display_reader u_disp (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (disp_start),
        .i_origin_x  (origin_x),
        .i_origin_y  (origin_y),
        .i_depth_sel (depth_sel),
        .o_done      (disp_done),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data),
        .o_banks     (banks)
    );

endmodule

// File: dv/img_core_tb.sv
`timescale 1ns/1ps
`include "img_macros.svh"

module img_core_tb;

    // run budget from the test list below
    localparam int N_LOADS    = 3;
    localparam int N_DISPLAYS = 20;
    localparam int N_OPS      = 90;
    localparam int LIMIT      = 2 * (N_LOADS * 4096 + N_DISPLAYS * 140 + N_OPS * 4);
    localparam int ORG_LIMIT  = 6;      // highest origin coordinate

    logic        i_clk;
    logic        i_rst_n;
    logic        i_op_valid;
    logic [3:0]  i_op_mode;
    logic        i_in_valid;
    logic [7:0]  i_in_data;
    logic        o_op_ready;
    logic        o_in_ready;
    logic        o_out_valid;
    logic [13:0] o_out_data;

    // reference model
    logic [7:0]  img [0:2047];          // raster index {c, y, x}
    int          org_x = 0;
    int          org_y = 0;
    int          depth = 32;            // channels shown

    logic [31:0] rng = 32'h2450;
    int          ready_cnt = 0;         // op_ready pulses seen
    int          ops_sent = 0;
    logic [13:0] out_mem [0:4095];      // captured display words
    int          out_cnt = 0;
    int          seen_cnt = 0;          // words already checked
    int          cycles = 0;
    int          errors = 0;
    int          errors_at = 0;
    int          tests_pass = 0;
    int          tests_fail = 0;
    string       cur_test;

    img_core dut (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_op_valid  (i_op_valid),
        .i_op_mode   (i_op_mode),
        .i_in_valid  (i_in_valid),
        .i_in_data   (i_in_data),
        .o_op_ready  (o_op_ready),
        .o_in_ready  (o_in_ready),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;    // 40 ns period
    end

    // --------------------------------------------------
    // edge bookkeeping and run limit
    // --------------------------------------------------
    always @(posedge i_clk) begin
        if (o_op_ready) ready_cnt <= ready_cnt + 1;
        if (o_out_valid) begin
            out_mem[out_cnt[11:0]] <= o_out_data;
            out_cnt                <= out_cnt + 1;
        end
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, a handshake never completed", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // origin moves and depth steps, clamped at both ends
    function automatic void model_op(input logic [3:0] op);
        case (op)
            `OP_ORG_R:   if (org_x < ORG_LIMIT) org_x++;
            `OP_ORG_L:   if (org_x > 0) org_x--;
            `OP_ORG_U:   if (org_y > 0) org_y--;
            `OP_ORG_D:   if (org_y < ORG_LIMIT) org_y++;
            `OP_SCALE_D: if (depth > 8) depth = depth / 2;
            `OP_SCALE_U: if (depth < 32) depth = depth * 2;
            default: ;  // load, display, undefined
        endcase
    endfunction

    task automatic begin_test(input string name);
        cur_test  = name;
        errors_at = errors;
    endtask

    task automatic finish_test();
        if (errors == errors_at) begin
            tests_pass++;
            $display("test %s: passed", cur_test);
        end else begin
            tests_fail++;
            $display("test %s: failed, %0d errors", cur_test, errors - errors_at);
        end
    endtask

    // one ready pulse per op, counted ahead of time
    task automatic wait_ready();
        while (ready_cnt == ops_sent) @(posedge i_clk);
    endtask

    task automatic send_op(input logic [3:0] op);
        wait_ready();
        ops_sent++;
        i_op_valid <= 1'b1;
        i_op_mode  <= op;
        @(posedge i_clk);
        i_op_valid <= 1'b0;
        model_op(op);
    endtask

    task automatic load_image();
        int          cnt;
        logic [31:0] r;
        for (int i = 0; i < `IMG_PIX; i++) begin
            r            = next_random();
            img[i[10:0]] = r[7:0];
        end
        send_op(`OP_LOAD);
        cnt = 0;
        while (cnt < `IMG_PIX) begin
            r = next_random();
            i_in_valid <= (r[1:0] != 2'd0);    // about one idle cycle in four
            i_in_data  <= img[cnt[10:0]];
            @(posedge i_clk);
            if (i_in_valid && o_in_ready) cnt++;
        end
        i_in_valid <= 1'b0;
        @(posedge i_clk);
        assert (!o_in_ready) else begin
            $display("%s: o_in_ready still high after the last pixel", cur_test);
            errors++;
        end
    endtask

    task automatic check_no_stray();
        assert (out_cnt == seen_cnt) else begin
            $display("%s: %0d output words arrived outside a DISPLAY", cur_test,
                     out_cnt - seen_cnt);
            errors++;
        end
        seen_cnt = out_cnt;
    endtask

    // --------------------------------------------------
    // display and word-by-word compare
    // --------------------------------------------------
    task automatic check_display();
        int          n;
        int          k;
        int          idx;
        int          j;
        logic [13:0] exp;
        logic [13:0] got;
        check_no_stray();
        send_op(`OP_DISPLAY);
        wait_ready();                   // stream complete once ready returns
        n = out_cnt - seen_cnt;
        assert (n == 4 * depth) else begin
            $display("%s: expected %0d display words, got %0d", cur_test, 4 * depth, n);
            errors++;
        end
        for (int c = 0; c < depth; c++) begin
            for (int p = 0; p < 4; p++) begin
                k   = 4 * c + p;
                idx = c * 64 + (org_y + p / 2) * 8 + org_x + p % 2;
                exp = {6'd0, img[idx[10:0]]};  // zero-extended
                if (k < n) begin
                    j   = seen_cnt + k;
                    got = out_mem[j[11:0]];
                    assert (got == exp) else begin
                        $display("Mismatch %s word %0d: expected %0h, actual %0h",
                                 cur_test, k, exp, got);
                        errors++;
                    end
                end
            end
        end
        seen_cnt = out_cnt;
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        logic [31:0] r;
        int          run;
        i_rst_n    = 1'b0;
        i_op_valid = 1'b0;
        i_op_mode  = '0;
        i_in_valid = 1'b0;
        i_in_data  = '0;
        repeat (8) @(posedge i_clk);
        i_rst_n <= 1'b1;

        begin_test("reset_defaults");
        load_image();
        check_display();               // (0,0), 32 channels
        finish_test();

        begin_test("load_gaps");
        load_image();
        repeat (4) begin
            repeat (2) begin
                r = next_random();
                send_op(`OP_ORG_R + {2'b00, r[1:0]});
            end
            check_display();
        end
        finish_test();

        begin_test("origin_clamp");
        for (int d = 0; d < 4; d++) begin
            r   = next_random();
            run = 7 + int'(r[0]);       // always reaches the edge
            repeat (run) send_op(`OP_ORG_R + d[3:0]);
            check_display();
        end
        finish_test();

        // 32 -> 16 -> 8 -> 16 -> 32 -> 8, long runs pass each end
        begin_test("depth_scale");
        for (int s = 0; s < 5; s++) begin
            r   = next_random();
            run = (s == 0 || s == 2) ? 1 : 3 + int'(r[0]);
            repeat (run) send_op((s == 2 || s == 3) ? `OP_SCALE_U : `OP_SCALE_D);
            check_display();
        end
        finish_test();

        begin_test("undefined_ops");
        repeat (3) begin
            repeat (2) begin
                r = next_random();
                send_op({1'b1, r[2:0]});    // opcodes 8..15
            end
            check_display();
        end
        finish_test();

        begin_test("reload");
        load_image();                  // origin and depth carry over
        check_display();
        finish_test();

        check_no_stray();
        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_pass, tests_fail, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+hdl
hdl/img_pkg.sv
hdl/bank_if.sv
hdl/pixel_bank.sv
hdl/op_ctrl.sv
hdl/load_writer.sv
hdl/display_reader.sv
hdl/img_core.sv
dv/img_core_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = img_core_tb
FILELIST  = list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "=== PASS ==="

clean:
	rm -rf obj_dir
